//--- source/stream_pkg.sv
//////////////////////////////////////////////////////////////////////
// stream_pkg package
// reduce_op_t operation enum, queue_state_t and seg_state_t state enums
//////////////////////////////////////////////////////////////////////

`default_nettype none

package stream_pkg;

   // reduction applied by the operator over each segment
   typedef enum logic [1:0] {
      op_pass  = 2'd0,   // forward every token unchanged
      op_sum   = 2'd1,   // segment sum modulo 2**WIDTH
      op_max   = 2'd2,   // unsigned maximum of the segment
      op_count = 2'd3    // number of tokens in the segment
   } reduce_op_t;

   // queue controller state
   typedef enum logic {
      q_empty    = 1'b0,   // o_v low, o_d holds last emitted value
      q_nonempty = 1'b1    // o_v high, addr+1 items stored
   } queue_state_t;

   // segment tracking in the operator control
   typedef enum logic {
      seg_idle = 1'b0,   // no segment open, next token loads accumulator
      seg_open = 1'b1    // at least one token of the segment absorbed
   } seg_state_t;

endpackage

`default_nettype wire

//--- source/stream_queue.sv
//////////////////////////////////////////////////////////////////////
// stream_queue module
// shifting in-page queue with registered full and almost-empty flags
//////////////////////////////////////////////////////////////////////

`default_nettype none

module stream_queue import stream_pkg::*; #(
   parameter int WIDTH = 17,   // token width, eos in the top bit
   parameter int DEPTH = 8     // greatest number of items, 2 to 256
) (
   input  logic             clock,
   input  logic             reset,
   // producer side
   input  logic [WIDTH-1:0] i_d,
   input  logic             i_v,
   output logic             o_b,
   // consumer side
   output logic [WIDTH-1:0] o_d,
   output logic             o_v,
   input  logic             i_b
);

   localparam int ADDR_WIDTH = $clog2(DEPTH);   // read address of the oldest item

   queue_state_t          state;
   queue_state_t          state_nxt;
   logic [ADDR_WIDTH-1:0] addr;        // index of the oldest stored item
   logic [ADDR_WIDTH-1:0] addr_nxt;
   logic                  addr_full;   // addr == DEPTH-1 this cycle
   logic                  full_nxt;
   logic                  addr_zero;   // addr == 0 this cycle
   logic                  zero_nxt;
   logic                  shift_en;    // push i_d into the array
   logic [WIDTH-1:0]      srl [DEPTH];

   assign o_d = srl[addr];                  // oldest item, or last one when empty
   assign o_v = (state == q_nonempty);      // straight from the state register
   assign o_b = addr_full;                  // registered full flag

   // control flops
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         state     <= q_empty;
         addr      <= '0;
         addr_full <= 1'b0;
         addr_zero <= 1'b1;
      end else begin
         state     <= state_nxt;
         addr      <= addr_nxt;
         addr_full <= full_nxt;
         addr_zero <= zero_nxt;
      end
   end

   // storage shifts toward higher index on every push
   always_ff @(posedge clock) begin
      if (shift_en) begin
         for (int i = DEPTH - 1; i > 0; i--) begin
            srl[i] <= srl[i-1];
         end
         srl[0] <= i_d;
      end
   end

   // next state, with both flags precomputed for the following cycle
   always_comb begin
      shift_en  = 1'b0;        // idle unless a case below says otherwise
      addr_nxt  = addr;
      full_nxt  = addr_full;
      zero_nxt  = addr_zero;
      state_nxt = state;
      case (state)
         q_empty: begin
            addr_nxt = '0;
            full_nxt = 1'b0;
            zero_nxt = 1'b1;
            if (i_v) begin                     // first item lands at srl[0]
               shift_en  = 1'b1;
               state_nxt = q_nonempty;
            end
         end
         q_nonempty: begin
            if (addr_full) begin               // full, input blocked by o_b
               if (!i_b) begin                 // produce only
                  addr_nxt = addr - 1'b1;
                  full_nxt = 1'b0;
                  zero_nxt = (addr == ADDR_WIDTH'(1));
               end
            end else if (i_v && i_b) begin     // consume only
               shift_en = 1'b1;
               addr_nxt = addr + 1'b1;
               full_nxt = (addr == ADDR_WIDTH'(DEPTH - 2));
               zero_nxt = 1'b0;
            end else if (i_v && !i_b) begin    // consume and produce, count unchanged
               shift_en = 1'b1;
            end else if (!i_v && !i_b) begin   // produce only
               if (addr_zero) begin
                  state_nxt = q_empty;         // last item leaves
               end else begin
                  addr_nxt = addr - 1'b1;
               end
               full_nxt = 1'b0;
               zero_nxt = addr_zero || (addr == ADDR_WIDTH'(1));
            end
         end
         default: begin
            state_nxt = q_empty;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- source/reduce_control.sv
//////////////////////////////////////////////////////////////////////
// reduce_control module
// firing rule and segment state machine for the reducing operator
//////////////////////////////////////////////////////////////////////

`default_nettype none

module reduce_control import stream_pkg::*; (
   input  logic       clock,
   input  logic       reset,
   input  reduce_op_t i_op,                 // change only while seg_idle
   // in-queue side
   input  logic       i_in_valid,
   input  logic       i_in_eos,
   output logic       o_in_backpressure,
   // out-queue side
   input  logic       i_out_backpressure,   // out-queue full flag
   output logic       o_out_valid,
   output logic       o_out_eos,
   // accumulator steering
   output logic       o_acc_load,
   output logic       o_acc_update
);

   seg_state_t state;
   seg_state_t state_nxt;
   logic       produces;   // current token writes a result
   logic       fire;       // current token is consumed this edge

   // pass emits every token, reductions emit only at segment end
   assign produces = (i_op == op_pass) || i_in_eos;

   // a token that emits needs room downstream, others never wait
   assign fire = i_in_valid && (!produces || !i_out_backpressure);

   assign o_in_backpressure = !fire;            // in-queue pops exactly on fire
   assign o_out_valid       = fire && produces; // write in the same edge

   // reduced results always close their segment
   assign o_out_eos = (i_op == op_pass) ? i_in_eos : 1'b1;

   // first token of a segment replaces the accumulator
   assign o_acc_load   = fire && (state == seg_idle);
   assign o_acc_update = fire && (state == seg_open);

   // segment tracking
   always_comb begin
      state_nxt = state;
      case (state)
         seg_idle: begin
            if (fire && !i_in_eos) begin
               state_nxt = seg_open;       // segment longer than one token
            end
         end
         seg_open: begin
            if (fire && i_in_eos) begin
               state_nxt = seg_idle;       // eos token closes it
            end
         end
         default: begin
            state_nxt = seg_idle;
         end
      endcase
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         state <= seg_idle;
      end else begin
         state <= state_nxt;
      end
   end

endmodule

`default_nettype wire

//--- source/reduce_alu.sv
//////////////////////////////////////////////////////////////////////
// reduce_alu module
// accumulator and combine logic for pass, sum, max and count
//////////////////////////////////////////////////////////////////////

`default_nettype none

module reduce_alu import stream_pkg::*; #(
   parameter int WIDTH = 16   // value width without eos
) (
   input  logic             clock,
   input  logic             reset,
   input  reduce_op_t       i_op,
   input  logic [WIDTH-1:0] i_value,    // value of the token being fired
   input  logic             i_load,     // first token of a segment
   input  logic             i_update,   // later token of a segment
   output logic [WIDTH-1:0] o_result    // combined value, to the out-queue
);

   logic [WIDTH-1:0] acc;   // running reduction of the open segment

   // combine current token with the accumulator
   always_comb begin
      case (i_op)
         op_pass: begin
            o_result = i_value;
         end
         op_sum: begin
            o_result = i_load ? i_value : acc + i_value;   // wraps mod 2**WIDTH
         end
         op_max: begin
            o_result = (i_load || (i_value > acc)) ? i_value : acc;   // unsigned
         end
         op_count: begin
            o_result = i_load ? WIDTH'(1) : acc + 1'b1;
         end
         default: begin
            o_result = i_value;
         end
      endcase
   end

   // result feeds back on every absorbed token
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         acc <= '0;
      end else if (i_load || i_update) begin
         acc <= o_result;
      end
   end

endmodule

`default_nettype wire

//--- source/stream_reduce_top.sv
//////////////////////////////////////////////////////////////////////
// stream_reduce_top module
// input queue, reduce control, alu and output queue
//////////////////////////////////////////////////////////////////////

`default_nettype none

module stream_reduce_top import stream_pkg::*; #(
   parameter int WIDTH = 16,   // value width, tokens carry one more bit for eos
   parameter int DEPTH = 8     // depth of each queue
) (
   input  logic           clock,
   input  logic           reset,
   input  reduce_op_t     i_op,
   // upstream
   input  logic [WIDTH:0] i_data,   // {eos, value}
   input  logic           i_valid,
   output logic           o_backpressure,
   // downstream
   output logic [WIDTH:0] o_data,   // {eos, value}
   output logic           o_valid,
   input  logic           i_backpressure
);

   logic [WIDTH:0]   in_data;            // head of the input queue
   logic             in_valid;
   logic             in_backpressure;    // low exactly when control fires
   logic             acc_load;
   logic             acc_update;
   logic [WIDTH-1:0] alu_result;
   logic             out_eos;
   logic             out_valid;
   logic             out_backpressure;   // out-queue full flag

   stream_queue #(
      .WIDTH (WIDTH + 1),
      .DEPTH (DEPTH)
   ) u_in_queue (
      .clock (clock),
      .reset (reset),
      .i_d   (i_data),
      .i_v   (i_valid),
      .o_b   (o_backpressure),
      .o_d   (in_data),
      .o_v   (in_valid),
      .i_b   (in_backpressure)
   );

   reduce_control u_control (
      .clock              (clock),
      .reset              (reset),
      .i_op               (i_op),
      .i_in_valid         (in_valid),
      .i_in_eos           (in_data[WIDTH]),
      .o_in_backpressure  (in_backpressure),
      .i_out_backpressure (out_backpressure),
      .o_out_valid        (out_valid),
      .o_out_eos          (out_eos),
      .o_acc_load         (acc_load),
      .o_acc_update       (acc_update)
   );

   reduce_alu #(
      .WIDTH (WIDTH)
   ) u_alu (
      .clock    (clock),
      .reset    (reset),
      .i_op     (i_op),
      .i_value  (in_data[WIDTH-1:0]),
      .i_load   (acc_load),
      .i_update (acc_update),
      .o_result (alu_result)
   );

   stream_queue #(
      .WIDTH (WIDTH + 1),
      .DEPTH (DEPTH)
   ) u_out_queue (
      .clock (clock),
      .reset (reset),
      .i_d   ({out_eos, alu_result}),   // eos goes back on top
      .i_v   (out_valid),
      .o_b   (out_backpressure),
      .o_d   (o_data),
      .o_v   (o_valid),
      .i_b   (i_backpressure)
   );

endmodule

`default_nettype wire

//--- sim/stream_reduce_asserts.sv
//////////////////////////////////////////////////////////////////////
// stream_reduce_asserts module with queue invariant checks
// bind into every stream_queue instance
//////////////////////////////////////////////////////////////////////

`default_nettype none

module stream_reduce_asserts import stream_pkg::*; #(
   parameter int DEPTH = 8
) (
   input logic                     clock,
   input logic                     reset,
   input queue_state_t             i_state,
   input logic [$clog2(DEPTH)-1:0] i_addr,
   input logic                     i_full,           // registered o_b
   input logic                     i_almost_empty,   // registered addr_zero
   input logic                     i_shift,          // push into storage
   input logic                     i_out_valid
);
   timeunit 1ns;
   timeprecision 1ps;

   int violations = 0;   // number of failed checks

   task automatic record_failure(input string what);
      $error("%s", what);
      violations++;
   endtask

   full_not_almost_empty: assert property (@(posedge clock) disable iff (!reset)
      i_full |-> !i_almost_empty)
      else record_failure("queue full and almost empty together");

   empty_addr_zero: assert property (@(posedge clock) disable iff (!reset)
      (i_state == q_empty) |-> (i_addr == '0))
      else record_failure("queue empty with nonzero address");

   // an invalid output means an empty queue with matching precomputed flags
   invalid_flags_empty: assert property (@(posedge clock) disable iff (!reset)
      !i_out_valid |-> (i_almost_empty && !i_full))
      else record_failure("queue output invalid while flags show stored items");

   full_no_push: assert property (@(posedge clock) disable iff (!reset)
      i_full |-> !i_shift)
      else record_failure("queue accepted a token while full");

endmodule

bind stream_queue stream_reduce_asserts #(
   .DEPTH (DEPTH)
) u_queue_asserts (
   .clock          (clock),
   .reset          (reset),
   .i_state        (state),
   .i_addr         (addr),
   .i_full         (addr_full),
   .i_almost_empty (addr_zero),
   .i_shift        (shift_en),
   .i_out_valid    (o_v)
);

`default_nettype wire

//--- sim/stream_reduce_tb.sv
//////////////////////////////////////////////////////////////////////
// stream_reduce_tb module
// clock, reset, driver, monitor, reference model, directed tests,
// watchdog and summary for stream_reduce_top
//////////////////////////////////////////////////////////////////////

`default_nettype none

module stream_reduce_tb import stream_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          WIDTH           = 16;
   localparam int          DEPTH           = 8;
   localparam int          CLK_PERIOD      = 100;
   localparam int          TOTAL_TOKENS    = 320;   // bound on tokens over all tests
   localparam int          WATCHDOG_CYCLES = TOTAL_TOKENS * 40 + 500;
   localparam logic [31:0] RAND_SEED       = 32'h855a68f4;

   typedef logic [WIDTH:0] token_t;   // {eos, value}

   logic       clock = 1'b0;
   logic       reset;
   reduce_op_t i_op;
   token_t     i_data;
   logic       i_valid;
   logic       o_backpressure;
   token_t     o_data;
   logic       o_valid;
   logic       i_backpressure;

   token_t tx_q[$];                // tokens of the current phase
   token_t exp_q[$];               // model output for the whole test
   token_t rx_q[$];                // tokens taken from o_data
   int     errors       = 0;
   int     tests        = 0;
   int     failed_tests = 0;
   int     errors_at_start;
   int     accepted     = 0;       // upstream transfers
   int     stall_pct    = 0;       // downstream stall chance in percent
   logic   hold_bp      = 1'b0;    // keeps i_backpressure high
   int     violations;

   stream_reduce_top #(
      .WIDTH (WIDTH),
      .DEPTH (DEPTH)
   ) i_dut (
      .clock          (clock),
      .reset          (reset),
      .i_op           (i_op),
      .i_data         (i_data),
      .i_valid        (i_valid),
      .o_backpressure (o_backpressure),
      .o_data         (o_data),
      .o_valid        (o_valid),
      .i_backpressure (i_backpressure)
   );

   always #(CLK_PERIOD / 2) clock = ~clock;

   // downstream stalls driven just after the edge
   always begin
      @(posedge clock);
      #1;
      i_backpressure = hold_bp || (($urandom % 100) < stall_pct);
   end

   always @(posedge clock) begin
      if (reset && i_valid && !o_backpressure) begin
         accepted++;
      end
   end

   task automatic collect_outputs();
      forever begin
         @(posedge clock);
         if (reset && o_valid && !i_backpressure) begin
            rx_q.push_back(o_data);   // token leaves the out-queue here
         end
      end
   endtask

   task automatic value_error(input string name, input logic [31:0] expv,
                              input logic [31:0] actv);
      $display("ERROR %s expected %0h actual %0h", name, expv, actv);
      errors++;
   endtask

   task automatic note_error(input string msg);
      $display("%s", msg);
      errors++;
   endtask

   // expected output from the per-operation rules
   function automatic void model_append(input reduce_op_t op);
      logic [WIDTH-1:0] seg[$];   // values of the open segment
      logic [WIDTH-1:0] result;
      foreach (tx_q[i]) begin
         seg.push_back(tx_q[i][WIDTH-1:0]);
         if (op == op_pass) begin
            exp_q.push_back(tx_q[i]);
         end else if (tx_q[i][WIDTH]) begin
            result = (op == op_count) ? WIDTH'(seg.size()) : '0;
            foreach (seg[k]) begin
               if (op == op_sum) result += seg[k];             // wraps
               if (op == op_max && seg[k] > result) result = seg[k];
            end
            exp_q.push_back({1'b1, result});
            seg.delete();
         end
      end
   endfunction

   // last token always closes its segment
   function automatic void add_tokens(input int n, input int eos_pct);
      for (int i = 0; i < n; i++) begin
         tx_q.push_back({(i == n - 1) || (($urandom % 100) < eos_pct), WIDTH'($urandom)});
      end
   endfunction

   function automatic void add_segments(input int nseg, input int max_len);
      int len;
      for (int s = 0; s < nseg; s++) begin
         len = (s % 3 == 0) ? 1 : 1 + int'($urandom % max_len);   // some single-token
         for (int k = 0; k < len; k++) begin
            tx_q.push_back({k == len - 1, WIDTH'($urandom)});
         end
      end
   endfunction

   task automatic send_tokens(input int gap_pct);
      int gap;
      foreach (tx_q[i]) begin
         gap = (($urandom % 100) < gap_pct) ? 1 + int'($urandom % 3) : 0;
         i_valid = 1'b0;
         repeat (gap) begin
            @(posedge clock);
            #1;
         end
         i_data  = tx_q[i];
         i_valid = 1'b1;
         do begin
            @(posedge clock);
         end while (o_backpressure);   // taken on the first edge with room
         #1;
      end
      i_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int n = 0;
      while (rx_q.size() < exp_q.size() && n < 40 * exp_q.size() + 50) begin
         @(posedge clock);
         #1;
         n++;
      end
      repeat (4) begin   // room for stray extra tokens
         @(posedge clock);
         #1;
      end
   endtask

   task automatic start_test();
      tx_q.delete();
      exp_q.delete();
      rx_q.delete();
      errors_at_start = errors;
      @(posedge clock);
      #1;
   endtask

   task automatic finish_test(input string name);
      foreach (exp_q[i]) begin
         if (i >= rx_q.size()) begin
            note_error($sformatf("%s: output token %0d never arrived, expected %0h",
                                 name, i, exp_q[i]));
         end else begin
            assert (rx_q[i] === exp_q[i])
               else value_error($sformatf("o_data[%0d]", i), exp_q[i], rx_q[i]);
         end
      end
      assert (rx_q.size() <= exp_q.size())
         else note_error($sformatf("%s: %0d more output tokens than expected",
                                   name, rx_q.size() - exp_q.size()));
      tests++;
      if (errors != errors_at_start) failed_tests++;
      $display("test %s %s", name, (errors == errors_at_start) ? "passed" : "failed");
   endtask

   // op changes only here once the previous phase drained
   task automatic run_phase(input reduce_op_t op, input int nseg, input int gap_pct);
      i_op = op;
      tx_q.delete();
      if (op == op_pass) add_tokens(4 * nseg, 20);
      else add_segments(nseg, 8);
      model_append(op);
      send_tokens(gap_pct);
      wait_drain();
   endtask

   task automatic reset_state_test();
      start_test();
      assert (o_valid === 1'b0) else value_error("o_valid", 0, o_valid);
      assert (o_backpressure === 1'b0) else value_error("o_backpressure", 0, o_backpressure);
      assert (i_dut.u_control.state === seg_idle)
         else value_error("u_control.state", seg_idle, i_dut.u_control.state);
      finish_test("reset");
   endtask

   task automatic backpressure_test();
      int n = 0;
      start_test();
      i_op    = op_pass;
      hold_bp = 1'b1;
      add_tokens(2 * DEPTH + 4, 20);
      model_append(op_pass);
      repeat (2) begin   // i_backpressure high before the first token
         @(posedge clock);
         #1;
      end
      accepted = 0;
      fork
         send_tokens(0);
         begin
            while (!o_backpressure && n < 8 * DEPTH) begin
               @(posedge clock);
               #1;
               n++;
            end
            repeat (4) begin
               @(posedge clock);
               #1;
            end
            assert (o_backpressure) else note_error("o_backpressure never rose with output held");
            assert (accepted == 2 * DEPTH)
               else value_error("accepted tokens", 2 * DEPTH, accepted);
            hold_bp = 1'b0;   // release so the rest of the list follows
         end
      join
      wait_drain();
      finish_test("backpressure");
   endtask

   initial begin
      void'($urandom(RAND_SEED));
      reset          = 1'b0;
      i_op           = op_pass;
      i_data         = '0;
      i_valid        = 1'b0;
      i_backpressure = 1'b0;
      fork
         collect_outputs();
      join_none
      repeat (16) @(posedge clock);
      #1;
      reset = 1'b1;
      reset_state_test();
      start_test();
      run_phase(op_pass, 10, 0);   // 40 tokens
      finish_test("pass");
      start_test();
      run_phase(op_sum, 6, 10);
      run_phase(op_max, 6, 10);
      run_phase(op_count, 6, 10);
      finish_test("reductions");
      backpressure_test();
      start_test();
      stall_pct = 40;
      run_phase(op_sum, 10, 30);
      stall_pct = 0;
      finish_test("stalls");
      start_test();
      run_phase(op_count, 4, 20);
      run_phase(op_max, 4, 20);
      run_phase(op_pass, 4, 20);
      finish_test("switch");
      violations = i_dut.u_in_queue.u_queue_asserts.violations
                 + i_dut.u_out_queue.u_queue_asserts.violations;
      assert (violations == 0)
         else note_error($sformatf("queue assertions failed %0d times", violations));
      $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
source/stream_pkg.sv
source/stream_queue.sv
source/reduce_control.sv
source/reduce_alu.sv
source/stream_reduce_top.sv
sim/stream_reduce_asserts.sv
sim/stream_reduce_tb.sv

//--- Bender.yml
package:
  name: stream_reduce

sources:
  # synthesizable sources, package first
  - files:
      - source/stream_pkg.sv
      - source/stream_queue.sv
      - source/reduce_control.sv
      - source/reduce_alu.sv
      - source/stream_reduce_top.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/stream_reduce_asserts.sv
      - sim/stream_reduce_tb.sv
